/* src.f */
+incdir+.
vlsu_pkg.sv
delta_counter.sv
reorder_buffer.sv
vlsu.sv
vector_regfile.sv
vlsu_top.sv
tb_mem_model.sv
tb_vlsu.sv

/* tb_vlsu.sv */
//////////////////////////////////////////////////////////////////////
// Testbench top for the load/store unit
// Clock, reset, stimulus table, checks and summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_vlsu
  import vlsu_pkg::*;
();

  localparam int TIMEOUT = 2000;
  localparam int NR_ROWS = 6;

  logic      clk;
  logic      rst;
  logic      stall;
  logic      cmd_valid;
  lsu_op_e   cmd_op;
  vreg_idx_t cmd_vd;
  elen_t     cmd_rs1;
  vlen_t     cmd_vl;
  vsew_e     cmd_vsew;
  logic      cmd_ready;
  logic      mem_valid;
  logic      mem_ready;
  elen_t     mem_addr;
  logic      mem_we;
  strb_t     mem_strb;
  elen_t     mem_wdata;
  id_t       mem_id;
  logic      res_valid;
  id_t       res_id;
  elen_t     res_rdata;

  int errors;
  logic timed_out;

  // Stimulus table, one operation per row
  lsu_op_e   row_op    [NR_ROWS];
  vreg_idx_t row_vd    [NR_ROWS];
  elen_t     row_rs1   [NR_ROWS];
  vlen_t     row_vl    [NR_ROWS];
  vsew_e     row_vsew  [NR_ROWS];
  int        row_stall [NR_ROWS];
  elen_t     row_exp   [NR_ROWS][8];

  // Previous cycle of the request port
  logic  hold_q = 1'b0;
  elen_t addr_q;
  logic  we_q;
  strb_t strb_q;
  elen_t wdata_q;
  id_t   id_q;

  vlsu_top DUT (
    .clk_i             (clk),
    .rst_i             (rst),
    .cmd_valid_i       (cmd_valid),
    .cmd_op_i          (cmd_op),
    .cmd_vd_i          (cmd_vd),
    .cmd_rs1_i         (cmd_rs1),
    .cmd_vl_i          (cmd_vl),
    .cmd_vsew_i        (cmd_vsew),
    .cmd_ready_o       (cmd_ready),
    .mem_valid_o       (mem_valid),
    .mem_ready_i       (mem_ready),
    .mem_addr_o        (mem_addr),
    .mem_we_o          (mem_we),
    .mem_strb_o        (mem_strb),
    .mem_wdata_o       (mem_wdata),
    .mem_id_o          (mem_id),
    .mem_result_valid_i(res_valid),
    .mem_result_id_i   (res_id),
    .mem_rdata_i       (res_rdata)
  );

  tb_mem_model u_mem (
    .clk_i      (clk),
    .rst_i      (rst),
    .stall_i    (stall),
    .req_valid_i(mem_valid),
    .req_ready_o(mem_ready),
    .req_addr_i (mem_addr),
    .req_we_i   (mem_we),
    .req_strb_i (mem_strb),
    .req_wdata_i(mem_wdata),
    .req_id_i   (mem_id),
    .res_valid_o(res_valid),
    .res_id_o   (res_id),
    .res_rdata_o(res_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Preloaded memory contents of a word address
  function automatic elen_t pattern(input int unsigned word);
    return elen_t'(word) * 32'h0101_0101 + 32'h11;
  endfunction

  function automatic strb_t expected_strb(input int bytes, input int w);
    int rem;
    rem = bytes - 4 * w;
    if (rem >= 4) begin
      return 4'hf;
    end
    return strb_t'((1 << rem) - 1);
  endfunction

  function automatic elen_t byte_mask(input strb_t strb);
    elen_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
  endtask

  task automatic add_row(input int r, input lsu_op_e op, input vreg_idx_t vd,
                         input elen_t rs1, input vlen_t vl, input vsew_e vsew,
                         input int stall_cycles, input int src_word);
    row_op[r]    = op;
    row_vd[r]    = vd;
    row_rs1[r]   = rs1;
    row_vl[r]    = vl;
    row_vsew[r]  = vsew;
    row_stall[r] = stall_cycles;
    for (int w = 0; w < 8; w++) begin
      row_exp[r][w] = pattern(src_word + w);
    end
  endtask

  task automatic build_table();
    // Round trip of register 2
    add_row(0, OP_VLE, 3'd2, 32'h040, 6'd8, EW_32, 0, 0);
    add_row(1, OP_VSE, 3'd2, 32'h200, 6'd8, EW_32, 0, 16);
    // Five bytes, partial tail word
    add_row(2, OP_VLE, 3'd5, 32'h100, 6'd5, EW_8, 0, 0);
    add_row(3, OP_VSE, 3'd5, 32'h300, 6'd5, EW_8, 0, 64);
    add_row(4, OP_VLE, 3'd1, 32'h000, 6'd0, EW_16, 0, 0);
    // Same store again behind a stalled memory
    add_row(5, OP_VSE, 3'd2, 32'h280, 6'd8, EW_32, 20, 16);
  endtask

  task automatic issue_cmd(input int r);
    int t;
    t = 0;
    while (cmd_ready !== 1'b1 && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (cmd_ready !== 1'b1) begin
      note_timeout("cmd_ready_o before a command");
      return;
    end
    cmd_valid = 1'b1;
    cmd_op    = row_op[r];
    cmd_vd    = row_vd[r];
    cmd_rs1   = row_rs1[r];
    cmd_vl    = row_vl[r];
    cmd_vsew  = row_vsew[r];
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (cmd_ready !== 1'b1 && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (cmd_ready !== 1'b1) begin
      note_timeout("the end of an operation");
    end
  endtask

  task automatic check_stores(input int r, input int base, input int bytes,
                              input int nwords);
    int    word;
    strb_t strb;
    elen_t mask;
    word = row_rs1[r] / 4;
    check_val("store count", u_mem.st_cnt - base, nwords);
    for (int w = 0; w < nwords; w++) begin
      word = row_rs1[r] / 4 + w;
      strb = expected_strb(bytes, w);
      mask = byte_mask(strb);
      check_val("mem_addr_o", u_mem.st_addr[base + w], row_rs1[r] + 4 * w);
      check_val("mem_strb_o", u_mem.st_strb[base + w], strb);
      check_val("mem_wdata_o", u_mem.st_data[base + w] & mask, row_exp[r][w] & mask);
      // Bytes outside the strobe keep their preloaded value
      check_val("memory word", u_mem.mem[word],
                (row_exp[r][w] & mask) | (pattern(word) & ~mask));
    end
    check_val("memory word", u_mem.mem[word + 1], pattern(word + 1));
  endtask

  task automatic run_row(input int r);
    int base;
    int reqs;
    int bytes;
    int nwords;
    base   = u_mem.st_cnt;
    reqs   = u_mem.req_cnt;
    bytes  = int'(row_vl[r]) << row_vsew[r];
    nwords = (bytes + 3) / 4;
    stall  = (row_stall[r] > 0);
    issue_cmd(r);
    if (timed_out) begin
      return;
    end
    if (row_stall[r] > 0) begin
      repeat (row_stall[r]) @(posedge clk);
      #1;
      check_val("mem_valid_o", mem_valid, 1'b1);
      stall = 1'b0;
    end
    wait_done();
    if (timed_out) begin
      return;
    end
    if (nwords == 0) begin
      // Quiet window before the next command
      repeat (4) begin
        @(posedge clk);
        #1;
        check_val("mem_valid_o", mem_valid, 1'b0);
      end
      check_val("request count", u_mem.req_cnt, reqs);
    end
    if (row_op[r] == OP_VSE) begin
      check_stores(r, base, bytes, nwords);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Request stability while the memory is not ready
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst && hold_q) begin
      check_val("mem_valid_o", mem_valid, 1'b1);
      check_val("mem_addr_o", mem_addr, addr_q);
      check_val("mem_we_o", mem_we, we_q);
      check_val("mem_strb_o", mem_strb, strb_q);
      check_val("mem_id_o", mem_id, id_q);
      if (we_q) begin
        check_val("mem_wdata_o", mem_wdata, wdata_q);
      end
    end
    hold_q  <= !rst && mem_valid && !mem_ready;
    addr_q  <= mem_addr;
    we_q    <= mem_we;
    strb_q  <= mem_strb;
    wdata_q <= mem_wdata;
    id_q    <= mem_id;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    errors    = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    stall     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_VLE;
    cmd_vd    = '0;
    cmd_rs1   = '0;
    cmd_vl    = '0;
    cmd_vsew  = EW_8;
    build_table();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("cmd_ready_o", cmd_ready, 1'b1);
    check_val("mem_valid_o", mem_valid, 1'b0);
    for (int r = 0; r < NR_ROWS && !timed_out; r++) begin
      run_row(r);
    end
    if (!timed_out && u_mem.ooo_cnt == 0) begin
      errors++;
      $display("Load results never came back out of order");
    end
    $display("Errors: %0d, out-of-order returns: %0d", errors, u_mem.ooo_cnt);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* tb_mem_model.sv */
//////////////////////////////////////////////////////////////////////
// Testbench memory for the load/store unit
// Answers loads in scrambled order, applies and logs stores
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_mem_model
  import vlsu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  stall_i,
  // Request side
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  elen_t req_addr_i,
  input  logic  req_we_i,
  input  strb_t req_strb_i,
  input  elen_t req_wdata_i,
  input  id_t   req_id_i,
  // Load results
  output logic  res_valid_o,
  output id_t   res_id_o,
  output elen_t res_rdata_o
);

  elen_t       mem [256];
  logic [3:0]  slot_vld;
  elen_t       slot_data [4];
  int          slot_seq [4];
  int          seq;
  // Store log, read by the checker
  elen_t       st_addr [64];
  elen_t       st_data [64];
  strb_t       st_strb [64];
  int          st_cnt;
  int          req_cnt;
  int          ooo_cnt;
  logic [31:0] lfsr;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = i * 32'h0101_0101 + 32'h11;
    end
    lfsr        = 32'ha5c;
    req_ready_o = 1'b0;
    res_valid_o = 1'b0;
    res_id_o    = '0;
    res_rdata_o = '0;
  end

  always @(posedge clk_i) begin : model
    logic [4:0] rnd;
    logic [1:0] k;
    logic       found;
    logic       ooo;
    if (rst_i) begin
      slot_vld = '0;
      seq      = 0;
      st_cnt   = 0;
      req_cnt  = 0;
      ooo_cnt  = 0;
      lfsr     = 32'ha5c;
      req_ready_o <= #1 1'b0;
      res_valid_o <= #1 1'b0;
    end else begin
      for (int i = 0; i < 5; i++) begin
        lfsr   = lfsr_step(lfsr);
        rnd[i] = lfsr[0];
      end
      // Return one held load, scanning from a random slot
      found = 1'b0;
      ooo   = 1'b0;
      if (rnd[0]) begin
        for (int i = 0; i < 4; i++) begin
          k = rnd[2:1] + 2'(i);
          if (!found && slot_vld[k]) begin
            found = 1'b1;
            for (int j = 0; j < 4; j++) begin
              if (slot_vld[j] && slot_seq[j] < slot_seq[k]) begin
                ooo = 1'b1;
              end
            end
            slot_vld[k] = 1'b0;
            res_id_o    <= #1 id_t'(k);
            res_rdata_o <= #1 slot_data[k];
          end
        end
      end
      if (ooo) begin
        ooo_cnt++;
      end
      res_valid_o <= #1 found;
      req_ready_o <= #1 (rnd[3] | rnd[4]) & ~stall_i;

      if (req_valid_i && req_ready_o) begin
        req_cnt++;
        if (req_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (req_strb_i[b]) begin
              mem[req_addr_i[9:2]][8*b +: 8] = req_wdata_i[8*b +: 8];
            end
          end
          if (st_cnt < 64) begin
            st_addr[st_cnt] = req_addr_i;
            st_data[st_cnt] = req_wdata_i;
            st_strb[st_cnt] = req_strb_i;
            st_cnt++;
          end
        end else begin
          // Slot index is the load id
          slot_vld[req_id_i]  = 1'b1;
          slot_data[req_id_i] = mem[req_addr_i[9:2]];
          slot_seq[req_id_i]  = seq;
          seq++;
        end
      end
    end
  end

endmodule

/* vlsu_top.sv */
//////////////////////////////////////////////////////////////////////
// Load/store unit top level
// Controller plus register file, command and memory ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vlsu_top
  import vlsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // Command port
  input  logic      cmd_valid_i,
  input  lsu_op_e   cmd_op_i,
  input  vreg_idx_t cmd_vd_i,
  input  elen_t     cmd_rs1_i,
  input  vlen_t     cmd_vl_i,
  input  vsew_e     cmd_vsew_i,
  output logic      cmd_ready_o,
  // Memory request
  output logic      mem_valid_o,
  input  logic      mem_ready_i,
  output elen_t     mem_addr_o,
  output logic      mem_we_o,
  output strb_t     mem_strb_o,
  output elen_t     mem_wdata_o,
  output id_t       mem_id_o,
  // Memory result
  input  logic      mem_result_valid_i,
  input  id_t       mem_result_id_i,
  input  elen_t     mem_rdata_i
);

  logic       vrf_re;
  vreg_addr_t vrf_raddr;
  elen_t      vrf_rdata;
  logic       vrf_rvalid;
  logic       vrf_we;
  vreg_addr_t vrf_waddr;
  elen_t      vrf_wdata;
  strb_t      vrf_wbe;

  vlsu i_vlsu (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_op_i          (cmd_op_i),
    .cmd_vd_i          (cmd_vd_i),
    .cmd_rs1_i         (cmd_rs1_i),
    .cmd_vl_i          (cmd_vl_i),
    .cmd_vsew_i        (cmd_vsew_i),
    .cmd_ready_o       (cmd_ready_o),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_addr_o        (mem_addr_o),
    .mem_we_o          (mem_we_o),
    .mem_strb_o        (mem_strb_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_id_o          (mem_id_o),
    .mem_result_valid_i(mem_result_valid_i),
    .mem_result_id_i   (mem_result_id_i),
    .mem_rdata_i       (mem_rdata_i),
    .vrf_re_o          (vrf_re),
    .vrf_raddr_o       (vrf_raddr),
    .vrf_rdata_i       (vrf_rdata),
    .vrf_rvalid_i      (vrf_rvalid),
    .vrf_we_o          (vrf_we),
    .vrf_waddr_o       (vrf_waddr),
    .vrf_wdata_o       (vrf_wdata),
    .vrf_wbe_o         (vrf_wbe)
  );

  vector_regfile i_vector_regfile (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .re_i    (vrf_re),
    .raddr_i (vrf_raddr),
    .rdata_o (vrf_rdata),
    .rvalid_o(vrf_rvalid),
    .we_i    (vrf_we),
    .waddr_i (vrf_waddr),
    .wdata_i (vrf_wdata),
    .wbe_i   (vrf_wbe)
  );

endmodule

/* vector_regfile.sv */
//////////////////////////////////////////////////////////////////////
// Vector register file
// Registered reads with a valid strobe, byte-enabled writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vlsu_config.svh"

module vector_regfile
  import vlsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Read port
  input  logic       re_i,
  input  vreg_addr_t raddr_i,
  output elen_t      rdata_o,
  output logic       rvalid_o,
  // Write port
  input  logic       we_i,
  input  vreg_addr_t waddr_i,
  input  elen_t      wdata_i,
  input  strb_t      wbe_i
);

  localparam int unsigned NR_WORDS = `VLSU_NR_VREGS * `VLSU_VREG_WORDS;

  elen_t mem_q [NR_WORDS];
  elen_t rdata_q;
  logic  rvalid_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem_q[raddr_i];
    end
  end

  // Data shows up one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= re_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

/* vlsu.sv */
//////////////////////////////////////////////////////////////////////
// Vector load/store controller
// Address generation, byte counters, tail strobes, buffer steering
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vlsu_config.svh"

module vlsu
  import vlsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Command port
  input  logic       cmd_valid_i,
  input  lsu_op_e    cmd_op_i,
  input  vreg_idx_t  cmd_vd_i,
  input  elen_t      cmd_rs1_i,
  input  vlen_t      cmd_vl_i,
  input  vsew_e      cmd_vsew_i,
  output logic       cmd_ready_o,
  // Memory request
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  output elen_t      mem_addr_o,
  output logic       mem_we_o,
  output strb_t      mem_strb_o,
  output elen_t      mem_wdata_o,
  output id_t        mem_id_o,
  // Memory result
  input  logic       mem_result_valid_i,
  input  id_t        mem_result_id_i,
  input  elen_t      mem_rdata_i,
  // Register file
  output logic       vrf_re_o,
  output vreg_addr_t vrf_raddr_o,
  input  elen_t      vrf_rdata_i,
  input  logic       vrf_rvalid_i,
  output logic       vrf_we_o,
  output vreg_addr_t vrf_waddr_o,
  output elen_t      vrf_wdata_o,
  output strb_t      vrf_wbe_o
);

  localparam vlen_t       WORD_BYTES = vlen_t'(`VLSU_ELEN / 8);
  localparam int unsigned WB_SHIFT   = $clog2(`VLSU_ELEN / 8);
  localparam int unsigned WIDX_W     = $clog2(`VLSU_VREG_WORDS);
  localparam int unsigned VREG_BYTES = `VLSU_VREG_WORDS * `VLSU_ELEN / 8;

  // Strobe for the bytes still to move, all ones unless this is the tail
  function automatic strb_t tail_strb(vlen_t rem);
    strb_t strb;
    strb = '1;
    if (rem < WORD_BYTES) begin
      strb = strb_t'((1 << rem) - 1);
    end
    return strb;
  endfunction

  // Latched command
  lsu_op_e   op_q;
  vreg_idx_t vd_q;
  elen_t     rs1_q;
  vlen_t     bytes_q;

  logic [$bits(vlen_t)+1:0] cmd_bytes;
  logic  new_req;
  logic  st_first;
  logic  is_load;
  logic  mem_busy;
  logic  vreg_busy;

  vlen_t mem_cnt;
  vlen_t vreg_cnt;
  logic  mem_fire;
  logic  vreg_cnt_en;
  vreg_addr_t vreg_addr;

  // Reorder buffer
  logic  buf_id_req;
  id_t   buf_id;
  logic  buf_push;
  id_t   buf_push_id;
  elen_t buf_wdata;
  logic  buf_pop;
  logic  buf_valid;
  elen_t buf_rdata;
  logic  buf_full;
  logic  buf_empty;
  id_t   rd_id_q;

  //////////////////////////////////////////////////////////////////////
  // Command
  //////////////////////////////////////////////////////////////////////

  assign cmd_bytes   = {2'b00, cmd_vl_i} << cmd_vsew_i;
  assign is_load     = (op_q == OP_VLE);
  assign mem_busy    = (mem_cnt < bytes_q);
  assign vreg_busy   = (vreg_cnt < bytes_q);
  assign cmd_ready_o = ~mem_busy & ~vreg_busy;
  assign new_req     = cmd_valid_i & cmd_ready_o;

  // Stores read their first word in the command cycle
  assign st_first = new_req & (cmd_op_i == OP_VSE) & (cmd_vl_i != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_q    <= OP_VLE;
      bytes_q <= '0;
    end else if (new_req) begin
      op_q    <= cmd_op_i;
      bytes_q <= vlen_t'(cmd_bytes);
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_req) begin
      vd_q  <= cmd_vd_i;
      rs1_q <= cmd_rs1_i;
    end
    // Id of the read now in flight, pushed when rvalid returns
    if (vrf_re_o) begin
      rd_id_q <= buf_id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  delta_counter i_mem_counter (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(new_req),
    .en_i   (mem_fire),
    .delta_i(WORD_BYTES),
    .q_o    (mem_cnt)
  );

  delta_counter i_vreg_counter (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(new_req),
    .en_i   (vreg_cnt_en),
    .delta_i(WORD_BYTES),
    .q_o    (vreg_cnt)
  );

  // Only one of the two is active for a given operation
  assign vreg_cnt_en = vrf_we_o | vrf_re_o;

  //////////////////////////////////////////////////////////////////////
  // Register file side
  //////////////////////////////////////////////////////////////////////

  assign vreg_addr   = {vd_q, vreg_cnt[WB_SHIFT +: WIDX_W]};

  assign vrf_re_o    = st_first | (~is_load & vreg_busy & ~buf_full);
  assign vrf_raddr_o = st_first ? {cmd_vd_i, {WIDX_W{1'b0}}} : vreg_addr;

  // Loads drain the buffer head into the register file
  assign vrf_we_o    = is_load & vreg_busy & buf_valid;
  assign vrf_waddr_o = vreg_addr;
  assign vrf_wdata_o = buf_rdata;
  assign vrf_wbe_o   = tail_strb(bytes_q - vreg_cnt);

  //////////////////////////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////////////////////////

  assign mem_valid_o = mem_busy & (is_load ? ~buf_full : buf_valid);
  assign mem_fire    = mem_valid_o & mem_ready_i;
  assign mem_addr_o  = rs1_q + elen_t'(mem_cnt);
  assign mem_we_o    = ~is_load;
  assign mem_strb_o  = tail_strb(bytes_q - mem_cnt);
  assign mem_wdata_o = buf_rdata;
  assign mem_id_o    = is_load ? buf_id : id_t'(mem_cnt >> WB_SHIFT);

  //////////////////////////////////////////////////////////////////////
  // Reorder buffer
  //////////////////////////////////////////////////////////////////////

  // Load ids at request time, store ids at register read time
  assign buf_id_req  = vrf_re_o | (is_load & mem_fire);
  assign buf_push    = is_load ? mem_result_valid_i : vrf_rvalid_i;
  assign buf_push_id = is_load ? mem_result_id_i : rd_id_q;
  assign buf_wdata   = is_load ? mem_rdata_i : vrf_rdata_i;
  assign buf_pop     = is_load ? vrf_we_o : mem_fire;

  reorder_buffer i_reorder_buffer (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .id_req_i (buf_id_req),
    .id_o     (buf_id),
    .push_i   (buf_push),
    .push_id_i(buf_push_id),
    .data_i   (buf_wdata),
    .pop_i    (buf_pop),
    .valid_o  (buf_valid),
    .data_o   (buf_rdata),
    .full_o   (buf_full),
    .empty_o  (buf_empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_base_aligned : assert property (
    @(posedge clk_i) disable iff (rst_i)
    new_req |-> (cmd_rs1_i[WB_SHIFT-1:0] == '0)
  ) else $error("vlsu: base address is not word aligned");

  a_bytes_fit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    new_req |-> (cmd_bytes <= VREG_BYTES)
  ) else $error("vlsu: byte count exceeds one register");

  // Previous operation must have drained every buffered word
  a_idle_empty : assert property (
    @(posedge clk_i) disable iff (rst_i)
    new_req |-> buf_empty
  ) else $error("vlsu: command taken with words left in the buffer");

endmodule

/* reorder_buffer.sv */
//////////////////////////////////////////////////////////////////////
// Reorder buffer for memory words
// Hands out ids, takes writes by id, releases words in id order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vlsu_config.svh"

module reorder_buffer
  import vlsu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  // Id allocation
  input  logic  id_req_i,
  output id_t   id_o,
  // Write by id
  input  logic  push_i,
  input  id_t   push_id_i,
  input  elen_t data_i,
  // In-order release
  input  logic  pop_i,
  output logic  valid_o,
  output elen_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned DEPTH = `VLSU_NR_OUTSTANDING;
  localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

  elen_t            data_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  id_t              head_q;
  id_t              tail_q;
  logic [CNT_W-1:0] count_q;

  logic             do_alloc;
  logic             do_pop;
  logic [CNT_W-1:0] push_ofs;

  assign do_alloc = id_req_i & ~full_o;
  assign do_pop   = pop_i & valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_alloc) begin
        tail_q <= tail_q + id_t'(1);
      end
      if (do_pop) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + id_t'(1);
      end
      // Never hits the head slot while it is being released
      if (push_i) begin
        valid_q[push_id_i] <= 1'b1;
      end
      count_q <= count_q + CNT_W'(do_alloc) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_id_i] <= data_i;
    end
  end

  assign id_o    = tail_q;
  assign valid_o = valid_q[head_q];
  assign data_o  = data_q[head_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Distance of the written slot from the oldest allocated id
  assign push_ofs = {1'b0, push_id_i - head_q};

  a_push_allocated : assert property (
    @(posedge clk_i) disable iff (rst_i)
    push_i |-> (push_ofs < count_q) && !valid_q[push_id_i]
  ) else $error("reorder_buffer: write to a slot that is not allocated");

  a_pop_valid : assert property (
    @(posedge clk_i) disable iff (rst_i)
    pop_i |-> valid_o
  ) else $error("reorder_buffer: release while the head is not valid");

endmodule

/* delta_counter.sv */
//////////////////////////////////////////////////////////////////////
// Byte position counter with clear and variable step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module delta_counter
  import vlsu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  clear_i,
  input  logic  en_i,
  input  vlen_t delta_i,
  output vlen_t q_o
);

  vlen_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      // A step in the clear cycle counts as the first one
      count_q <= en_i ? delta_i : '0;
    end else if (en_i) begin
      count_q <= count_q + delta_i;
    end
  end

  assign q_o = count_q;

endmodule

/* vlsu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types of the vector load/store unit
//////////////////////////////////////////////////////////////////////

`include "vlsu_config.svh"

package vlsu_pkg;

  // One memory / register file word and its byte enable
  typedef logic [`VLSU_ELEN-1:0]   elen_t;
  typedef logic [`VLSU_ELEN/8-1:0] strb_t;

  // Register number, and register number followed by word index
  typedef logic [$clog2(`VLSU_NR_VREGS)-1:0]                     vreg_idx_t;
  typedef logic [$clog2(`VLSU_NR_VREGS*`VLSU_VREG_WORDS)-1:0]    vreg_addr_t;

  // Byte count within one register, one extra bit so a full register fits
  typedef logic [$clog2(`VLSU_VREG_WORDS*`VLSU_ELEN/8):0]        vlen_t;

  // Load id, also a reorder buffer slot
  typedef logic [$clog2(`VLSU_NR_OUTSTANDING)-1:0]               id_t;

  typedef enum logic {
    OP_VLE = 1'b0,
    OP_VSE = 1'b1
  } lsu_op_e;

  // Encoded as log2 of the element bytes
  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vsew_e;

endpackage

/* vlsu_config.svh */
//////////////////////////////////////////////////////////////////////
// Configuration macros for the vector load/store unit
// Word width, register file geometry and load ids in flight
//////////////////////////////////////////////////////////////////////

`ifndef VLSU_CONFIG_SVH
`define VLSU_CONFIG_SVH

// Memory and register file word width in bits
`define VLSU_ELEN 32

// Register file geometry
`define VLSU_NR_VREGS 8
`define VLSU_VREG_WORDS 8

// Reorder buffer entries, one per load id
`define VLSU_NR_OUTSTANDING 4

`endif
